/* src/cpuPkg.sv */
package cpuPkg;

    localparam int XLEN = 32;

    // widths with a meaning of their own
    typedef logic [XLEN-1:0] word_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      regAddr_t;

    // ALU operations, shifts take the low 5 bits of operand B
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB
    } aluOp_e;

    // operand A source
    typedef enum logic [1:0] {
        srcARs1,
        srcAPc,
        srcAZero
    } srcA_e;

    // operand B source
    typedef enum logic {
        srcBRs2,
        srcBImm
    } srcB_e;

    // everything the ALU stage needs for one instruction
    typedef struct packed {
        aluOp_e   aluOp;
        srcA_e    srcA;
        srcB_e    srcB;
        word_t    imm;
        word_t    pc;
        word_t    rs1Data;
        word_t    rs2Data;
        regAddr_t rd;
        logic     regWr;
    } decodedOp_t;

    // one writeback to the register file
    typedef struct packed {
        regAddr_t rd;
        word_t    data;
    } wbResult_t;

    // RV32I major opcodes handled by this core
    localparam logic [6:0] opcOp    = 7'b0110011;
    localparam logic [6:0] opcOpImm = 7'b0010011;
    localparam logic [6:0] opcLui   = 7'b0110111;
    localparam logic [6:0] opcAuipc = 7'b0010111;

endpackage

/* src/ctrlGen.sv */
`timescale 1ns/1ps

module ctrlGen (
    input  cpuPkg::inst_t      inst_i,
    output cpuPkg::decodedOp_t op_o
);
    import cpuPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    regAddr_t   rd;
    word_t      immI;
    word_t      immU;
    aluOp_e     aluFn;

    // instruction fields
    assign opcode   = inst_i[6:0];
    assign funct3   = inst_i[14:12];
    assign funct7b5 = inst_i[30];
    assign rd       = inst_i[11:7];

    // sign extended 12-bit immediate
    assign immI = {{20{inst_i[31]}}, inst_i[31:20]};
    // upper immediate, low 12 bits zero
    assign immU = {inst_i[31:12], 12'b0};

    // funct3 mapping common to OP and OP-IMM
    // bit 30 picks arithmetic right shift in both formats
    always_comb begin
        case (funct3)
            3'b000: begin
                aluFn = aluAdd;
            end
            3'b001: begin
                aluFn = aluSll;
            end
            3'b010: begin
                aluFn = aluSlt;
            end
            3'b011: begin
                aluFn = aluSltu;
            end
            3'b100: begin
                aluFn = aluXor;
            end
            3'b101: begin
                aluFn = funct7b5 ? aluSra : aluSrl;
            end
            3'b110: begin
                aluFn = aluOr;
            end
            default: begin
                aluFn = aluAnd;
            end
        endcase
    end

    always_comb begin
        // pc and operand data are filled in by the decode stage
        op_o       = '0;
        op_o.aluOp = aluAdd;
        op_o.srcA  = srcAZero;
        op_o.srcB  = srcBImm;
        op_o.rd    = rd;

        case (opcode)
            opcOp: begin
                // only register-register add has a sub variant
                op_o.aluOp = (funct3 == 3'b000 && funct7b5) ? aluSub : aluFn;
                op_o.srcA  = srcARs1;
                op_o.srcB  = srcBRs2;
                op_o.regWr = 1'b1;
            end
            opcOpImm: begin
                op_o.aluOp = aluFn;
                op_o.srcA  = srcARs1;
                op_o.srcB  = srcBImm;
                op_o.imm   = immI;
                op_o.regWr = 1'b1;
            end
            opcLui: begin
                op_o.aluOp = aluPassB;
                op_o.imm   = immU;
                op_o.regWr = 1'b1;
            end
            opcAuipc: begin
                op_o.aluOp = aluAdd;
                op_o.srcA  = srcAPc;
                op_o.imm   = immU;
                op_o.regWr = 1'b1;
            end
            default: begin
                // unsupported opcode travels on as a bubble
                op_o.regWr = 1'b0;
            end
        endcase

        // writes to x0 are dropped here
        if (rd == '0) begin
            op_o.regWr = 1'b0;
        end
    end

endmodule

/* src/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic             clk_i,
    input  logic             arstN_i,
    input  cpuPkg::regAddr_t rs1Addr_i,
    input  cpuPkg::regAddr_t rs2Addr_i,
    output cpuPkg::word_t    rs1Data_o,
    output cpuPkg::word_t    rs2Data_o,
    input  logic             wrEn_i,
    input  cpuPkg::regAddr_t wrAddr_i,
    input  cpuPkg::word_t    wrData_i
);
    import cpuPkg::*;

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn_i && wrAddr_i != '0) begin
            regs[wrAddr_i] <= wrData_i;
        end
    end

    // reads see the value before this cycle's write
    assign rs1Data_o = (rs1Addr_i == '0) ? '0 : regs[rs1Addr_i];
    assign rs2Data_o = (rs2Addr_i == '0) ? '0 : regs[rs2Addr_i];

endmodule

/* src/writeTracker.sv */
`timescale 1ns/1ps

module writeTracker #(
    parameter int TRACK_DEPTH = 4
) (
    input  logic             clk_i,
    input  logic             arstN_i,
    input  logic             push_i,
    input  cpuPkg::regAddr_t pushRd_i,
    input  logic             pop_i,
    input  cpuPkg::regAddr_t rs1_i,
    input  cpuPkg::regAddr_t rs2_i,
    output logic             raw_o,
    output logic             full_o
);
    import cpuPkg::*;

    localparam int PtrW = (TRACK_DEPTH > 1) ? $clog2(TRACK_DEPTH) : 1;
    localparam int CntW = $clog2(TRACK_DEPTH + 1);

    regAddr_t            rdQ [TRACK_DEPTH];
    logic [TRACK_DEPTH-1:0] vld;
    logic [PtrW-1:0]     wrPtr;
    logic [PtrW-1:0]     rdPtr;
    logic [CntW-1:0]     count;

    // pointers wrap explicitly so any depth works
    function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
        return (ptr == PtrW'(TRACK_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            vld   <= '0;
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push_i) begin
                vld[wrPtr] <= 1'b1;
                wrPtr      <= nextPtr(wrPtr);
            end
            // completion is in issue order, oldest entry retires
            if (pop_i) begin
                vld[rdPtr] <= 1'b0;
                rdPtr      <= nextPtr(rdPtr);
            end
            if (push_i && !pop_i) begin
                count <= count + 1'b1;
            end else if (pop_i && !push_i) begin
                count <= count - 1'b1;
            end
        end
    end

    // destination payload
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            rdQ[wrPtr] <= pushRd_i;
        end
    end

    always_comb begin
        raw_o = 1'b0;
        for (int i = 0; i < TRACK_DEPTH; i++) begin
            if (vld[i] && rdQ[i] != '0 && (rdQ[i] == rs1_i || rdQ[i] == rs2_i)) begin
                raw_o = 1'b1;
            end
        end
    end

    assign full_o = (count == CntW'(TRACK_DEPTH));

endmodule

/* src/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
    input  logic               clk_i,
    input  logic               arstN_i,
    // fetch side
    input  logic               ifValid_i,
    input  cpuPkg::inst_t      ifInst_i,
    input  cpuPkg::word_t      ifPc_i,
    output logic               ifReady_o,
    // register file reads
    output cpuPkg::regAddr_t   rs1Addr_o,
    output cpuPkg::regAddr_t   rs2Addr_o,
    input  cpuPkg::word_t      rs1Data_i,
    input  cpuPkg::word_t      rs2Data_i,
    // write tracker
    input  logic               raw_i,
    input  logic               full_i,
    output logic               trackPush_o,
    output cpuPkg::regAddr_t   trackRd_o,
    // ALU side
    output logic               idValid_o,
    output cpuPkg::decodedOp_t idOp_o,
    input  logic               exReady_i
);
    import cpuPkg::*;

    logic       idValid;
    decodedOp_t idOp;
    decodedOp_t ctrlOp;
    decodedOp_t decOp;
    logic       accept;

    ctrlGen uCtrlGen (
        .inst_i (ifInst_i),
        .op_o   (ctrlOp)
    );

    // source fields go straight to the register file and tracker
    assign rs1Addr_o = ifInst_i[19:15];
    assign rs2Addr_o = ifInst_i[24:20];

    // merge control with pc and operand values
    always_comb begin
        decOp         = ctrlOp;
        decOp.pc      = ifPc_i;
        decOp.rs1Data = rs1Data_i;
        decOp.rs2Data = rs2Data_i;
    end

    // stage empty or being drained, and no hazard pending
    assign ifReady_o = (!idValid || exReady_i) && !raw_i && !full_i;
    assign accept    = ifValid_i && ifReady_o;

    // only writing instructions are tracked, x0 already cleared in ctrlGen
    assign trackPush_o = accept && decOp.regWr;
    assign trackRd_o   = decOp.rd;

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            idValid <= 1'b0;
        end else if (accept) begin
            idValid <= 1'b1;
        end else if (exReady_i) begin
            idValid <= 1'b0;
        end
    end

    // pipeline register, held while the ALU stalls
    always_ff @(posedge clk_i) begin
        if (accept) begin
            idOp <= decOp;
        end
    end

    assign idValid_o = idValid;
    assign idOp_o    = idOp;

endmodule

/* src/aluStage.sv */
`timescale 1ns/1ps

module aluStage (
    input  logic               clk_i,
    input  logic               arstN_i,
    input  logic               idValid_i,
    input  cpuPkg::decodedOp_t idOp_i,
    output logic               exReady_o,
    output logic               wbValid_o,
    output cpuPkg::wbResult_t  wbResult_o,
    input  logic               wbReady_i
);
    import cpuPkg::*;

    word_t     opA;
    word_t     opB;
    word_t     aluOut;
    logic [4:0] shamt;
    logic      accept;
    logic      wbValid;
    wbResult_t wbResult;

    // operand muxes
    always_comb begin
        case (idOp_i.srcA)
            srcARs1: opA = idOp_i.rs1Data;
            srcAPc:  opA = idOp_i.pc;
            default: opA = '0;
        endcase
        opB = (idOp_i.srcB == srcBRs2) ? idOp_i.rs2Data : idOp_i.imm;
    end

    assign shamt = opB[4:0];

    always_comb begin
        case (idOp_i.aluOp)
            aluAdd:   aluOut = opA + opB;
            aluSub:   aluOut = opA - opB;
            aluSll:   aluOut = opA << shamt;
            aluSlt:   aluOut = word_t'($signed(opA) < $signed(opB));
            aluSltu:  aluOut = word_t'(opA < opB);
            aluXor:   aluOut = opA ^ opB;
            aluSrl:   aluOut = opA >> shamt;
            aluSra:   aluOut = word_t'($signed(opA) >>> shamt);
            aluOr:    aluOut = opA | opB;
            aluAnd:   aluOut = opA & opB;
            default:  aluOut = opB;
        endcase
    end

    // result register empty or draining this cycle
    assign exReady_o = !wbValid || wbReady_i;
    assign accept    = idValid_i && exReady_o;

    // bubbles are taken and never show up as a writeback
    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            wbValid <= 1'b0;
        end else if (accept) begin
            wbValid <= idOp_i.regWr;
        end else if (wbReady_i) begin
            wbValid <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept && idOp_i.regWr) begin
            wbResult.rd   <= idOp_i.rd;
            wbResult.data <= aluOut;
        end
    end

    assign wbValid_o  = wbValid;
    assign wbResult_o = wbResult;

endmodule

/* src/coreDecodeTop.sv */
`timescale 1ns/1ps

module coreDecodeTop #(
    parameter int TRACK_DEPTH = 4
) (
    input  logic              clk_i,
    input  logic              arstN_i,
    input  logic              ifValid_i,
    input  cpuPkg::inst_t     ifInst_i,
    input  cpuPkg::word_t     ifPc_i,
    output logic              ifReady_o,
    output logic              wbValid_o,
    output cpuPkg::wbResult_t wbResult_o,
    input  logic              wbReady_i
);
    import cpuPkg::*;

    regAddr_t   rs1Addr;
    regAddr_t   rs2Addr;
    word_t      rs1Data;
    word_t      rs2Data;
    logic       raw;
    logic       full;
    logic       trackPush;
    regAddr_t   trackRd;
    logic       idValid;
    decodedOp_t idOp;
    logic       exReady;
    logic       wbFire;

    // commit and tracker retire happen on the same handshake
    assign wbFire = wbValid_o && wbReady_i;

    decodeStage uDecode (
        .clk_i       (clk_i),
        .arstN_i     (arstN_i),
        .ifValid_i   (ifValid_i),
        .ifInst_i    (ifInst_i),
        .ifPc_i      (ifPc_i),
        .ifReady_o   (ifReady_o),
        .rs1Addr_o   (rs1Addr),
        .rs2Addr_o   (rs2Addr),
        .rs1Data_i   (rs1Data),
        .rs2Data_i   (rs2Data),
        .raw_i       (raw),
        .full_i      (full),
        .trackPush_o (trackPush),
        .trackRd_o   (trackRd),
        .idValid_o   (idValid),
        .idOp_o      (idOp),
        .exReady_i   (exReady)
    );

    regFile uRegFile (
        .clk_i     (clk_i),
        .arstN_i   (arstN_i),
        .rs1Addr_i (rs1Addr),
        .rs2Addr_i (rs2Addr),
        .rs1Data_o (rs1Data),
        .rs2Data_o (rs2Data),
        .wrEn_i    (wbFire),
        .wrAddr_i  (wbResult_o.rd),
        .wrData_i  (wbResult_o.data)
    );

    writeTracker #(
        .TRACK_DEPTH (TRACK_DEPTH)
    ) uTracker (
        .clk_i    (clk_i),
        .arstN_i  (arstN_i),
        .push_i   (trackPush),
        .pushRd_i (trackRd),
        .pop_i    (wbFire),
        .rs1_i    (rs1Addr),
        .rs2_i    (rs2Addr),
        .raw_o    (raw),
        .full_o   (full)
    );

    aluStage uAlu (
        .clk_i      (clk_i),
        .arstN_i    (arstN_i),
        .idValid_i  (idValid),
        .idOp_i     (idOp),
        .exReady_o  (exReady),
        .wbValid_o  (wbValid_o),
        .wbResult_o (wbResult_o),
        .wbReady_i  (wbReady_i)
    );

endmodule

/* dv/tbModel.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// architectural registers, updated in program order
word_t     modelRegs [32];
// writebacks still owed by the DUT, oldest first
wbResult_t expQ [$];

task automatic clearModel();
    for (int i = 0; i < 32; i++) begin
        modelRegs[i] = '0;
    end
    expQ.delete();
endtask

function automatic inst_t encR(logic [6:0] f7, regAddr_t rs2, regAddr_t rs1,
                               logic [2:0] f3, regAddr_t rd);
    return {f7, rs2, rs1, f3, rd, opcOp};
endfunction

function automatic inst_t encI(logic [11:0] imm, regAddr_t rs1, logic [2:0] f3, regAddr_t rd);
    return {imm, rs1, f3, rd, opcOpImm};
endfunction

function automatic inst_t encU(logic [6:0] opc, logic [19:0] imm, regAddr_t rd);
    return {imm, rd, opc};
endfunction

// RV32I integer rules, alt is instruction bit 30
function automatic word_t refAlu(logic [2:0] f3, logic alt, logic isReg, word_t a, word_t b);
    word_t res;
    case (f3)
        3'b000: res = (isReg && alt) ? a - b : a + b;
        3'b001: res = a << b[4:0];
        3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011: res = (a < b) ? 32'd1 : 32'd0;
        3'b100: res = a ^ b;
        3'b101: res = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110: res = a | b;
        default: res = a & b;
    endcase
    return res;
endfunction

// one instruction as seen by the fetch port
task automatic modelStep(input inst_t inst, input word_t pc);
    logic [6:0] opc;
    regAddr_t   rd;
    word_t      a;
    word_t      res;
    logic       writes;
    wbResult_t  entry;
    opc    = inst[6:0];
    rd     = inst[11:7];
    a      = modelRegs[inst[19:15]];
    writes = 1'b1;
    case (opc)
        opcOp: res = refAlu(inst[14:12], inst[30], 1'b1, a, modelRegs[inst[24:20]]);
        opcOpImm: res = refAlu(inst[14:12], inst[30], 1'b0, a, {{20{inst[31]}}, inst[31:20]});
        opcLui: res = {inst[31:12], 12'b0};
        opcAuipc: res = pc + {inst[31:12], 12'b0};
        default: begin
            res    = '0;
            writes = 1'b0;
        end
    endcase
    if (writes && rd != '0) begin
        modelRegs[rd] = res;
        entry.rd      = rd;
        entry.data    = res;
        expQ.push_back(entry);
    end
endtask

`endif

/* dv/tbTop.sv */
`timescale 1ns/1ps

module tbTop;
    import cpuPkg::*;

    localparam int maxWait    = 2000;
    localparam int driveDelay = 5;
    // same as the DUT default
    localparam int trackDepth = 4;

    logic      clk;
    logic      arstN;
    logic      ifValid;
    inst_t     ifInst;
    word_t     ifPc;
    logic      ifReady;
    logic      wbValid;
    wbResult_t wbResult;
    logic      wbReady;

    int        errors = 0;
    int        checks = 0;
    int        testsRun = 0;
    int        testsFailed = 0;
    int        fetched = 0;
    int        written = 0;
    int        bpMode = 0;
    int        holdLeft = 0;
    logic      holdPending = 1'b0;
    logic      timedOut = 1'b0;
    wbResult_t heldResult;
    word_t     nextPc;

    `include "tbModel.svh"

    coreDecodeTop dut_i (
        .clk_i      (clk),
        .arstN_i    (arstN),
        .ifValid_i  (ifValid),
        .ifInst_i   (ifInst),
        .ifPc_i     (ifPc),
        .ifReady_o  (ifReady),
        .wbValid_o  (wbValid),
        .wbResult_o (wbResult),
        .wbReady_i  (wbReady)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // back-pressure mode 0 always ready, 1 short random lows, 2 long spans, 3 forced low
    // runs one step after the fetch driver so random draws keep a fixed order
    initial begin
        wbReady = 1'b1;
        forever begin
            @(posedge clk);
            #(driveDelay + 1);
            case (bpMode)
                0: wbReady = 1'b1;
                1: wbReady = ($urandom_range(0, 3) != 0);
                2: begin
                    if (holdLeft > 0) begin
                        holdLeft--;
                    end else begin
                        wbReady  = ~wbReady;
                        holdLeft = wbReady ? $urandom_range(1, 6) : $urandom_range(8, 40);
                    end
                end
                default: begin
                    if (holdLeft > 0) begin
                        wbReady = 1'b0;
                        holdLeft--;
                    end else begin
                        wbReady = 1'b1;
                        bpMode  = 0;
                    end
                end
            endcase
        end
    end

    // both handshakes sampled mid cycle where everything is settled
    always @(negedge clk) begin
        wbResult_t expected;
        if (arstN) begin
            if (ifValid && ifReady) begin
                modelStep(ifInst, ifPc);
                fetched++;
            end
            if (holdPending) begin
                checks++;
                assert (wbValid && wbResult == heldResult) else begin
                    errors++;
                    $display("FAIL %0d ns: stalled writeback changed from x%0d %h to x%0d %h",
                             $time, heldResult.rd, heldResult.data, wbResult.rd, wbResult.data);
                end
            end
            if (wbValid && wbReady) begin
                written++;
                checks++;
                assert (expQ.size() > 0) else begin
                    errors++;
                    $display("writeback to x%0d at %0d ns came with no instruction expecting it",
                             wbResult.rd, $time);
                end
                if (expQ.size() > 0) begin
                    expected = expQ.pop_front();
                    checks++;
                    assert (wbResult == expected) else begin
                        errors++;
                        $display("FAIL %0d ns: writeback x%0d %h, expected x%0d %h",
                                 $time, wbResult.rd, wbResult.data, expected.rd, expected.data);
                    end
                end
            end
            holdPending = wbValid && !wbReady;
            heldResult  = wbResult;
        end
    end

    task automatic reportAndFinish();
        $display("%0d tests, %0d failed, %0d fetched, %0d written back, %0d checks, %0d errors",
                 testsRun, testsFailed, fetched, written, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    // later fetches and drains are skipped once a wait has run out
    task automatic noteTimeout(input string reason);
        errors++;
        timedOut = 1'b1;
        $display("%s at %0d ns, skipping the remaining stimulus", reason, $time);
    endtask

    // entered and left a few ns after a rising edge
    task automatic sendInst(input inst_t inst);
        int   waited;
        logic accepted;
        if (timedOut) begin
            return;
        end
        ifValid = 1'b1;
        ifInst  = inst;
        ifPc    = nextPc;
        waited  = 0;
        @(negedge clk);
        while (!ifReady && waited < maxWait) begin
            @(negedge clk);
            waited++;
        end
        accepted = ifReady;
        @(posedge clk);
        #driveDelay;
        ifValid = 1'b0;
        if (accepted) begin
            nextPc = nextPc + 32'd4;
        end else begin
            noteTimeout("fetch port never became ready");
        end
    endtask

    task automatic waitDrain();
        int   waited;
        logic drained;
        if (timedOut) begin
            return;
        end
        waited = 0;
        @(negedge clk);
        while ((expQ.size() != 0 || wbValid) && waited < maxWait) begin
            @(negedge clk);
            waited++;
        end
        drained = (expQ.size() == 0 && !wbValid);
        @(posedge clk);
        #driveDelay;
        if (!drained) begin
            noteTimeout("expected writebacks never arrived");
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #driveDelay;
        end
    endtask

    task automatic endTest(input string name, input int errBefore);
        testsRun++;
        if (errors != errBefore) begin
            testsFailed++;
        end
        $display("test %s: %s", name, (errors == errBefore) ? "ok" : "errors seen");
    endtask

    // legal OP or OP-IMM encoding with registers up to regHi
    function automatic inst_t randAlu(int regHi);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        regAddr_t    rd;
        regAddr_t    rs1;
        regAddr_t    rs2;
        f3  = 3'($urandom_range(0, 7));
        rd  = regAddr_t'($urandom_range(1, regHi));
        rs1 = regAddr_t'($urandom_range(0, regHi));
        rs2 = regAddr_t'($urandom_range(0, regHi));
        f7  = ($urandom_range(0, 1) == 1) ? 7'b0100000 : 7'b0;
        if ($urandom_range(0, 1) == 0) begin
            // only add and shift right have an alternate form
            return encR((f3 == 3'b000 || f3 == 3'b101) ? f7 : 7'b0, rs2, rs1, f3, rd);
        end
        imm = 12'($urandom);
        if (f3 == 3'b001) begin
            imm = {7'b0, imm[4:0]};
        end else if (f3 == 3'b101) begin
            imm = {f7, imm[4:0]};
        end
        return encI(imm, rs1, f3, rd);
    endfunction

    function automatic inst_t randUpper(int regHi);
        logic [6:0] opc;
        opc = ($urandom_range(0, 1) == 1) ? opcAuipc : opcLui;
        return encU(opc, 20'($urandom), regAddr_t'($urandom_range(1, regHi)));
    endfunction

    task automatic randomMix(input int count, input int regHi, input int upperPct);
        for (int i = 0; i < count; i++) begin
            if ($urandom_range(0, 99) < upperPct) begin
                sendInst(randUpper(regHi));
            end else begin
                sendInst(randAlu(regHi));
            end
            if ($urandom_range(0, 3) == 0) begin
                idleCycles($urandom_range(1, 4));
            end
        end
    endtask

    initial begin
        int errBefore;
        logic [6:0] opc;
        regAddr_t   prevRd;
        regAddr_t   rd;
        void'($urandom(32'h1bdd_8b9a));
        arstN   = 1'b0;
        ifValid = 1'b0;
        ifInst  = '0;
        ifPc    = '0;
        nextPc  = 32'h0000_1000;
        clearModel();
        repeat (16) @(posedge clk);
        #driveDelay;
        arstN = 1'b1;

        errBefore = errors;
        checks++;
        assert (!wbValid && ifReady) else begin
            errors++;
            $display("FAIL %0d ns: after reset wbValid is %b and ifReady is %b",
                     $time, wbValid, ifReady);
        end
        sendInst(encR(7'b0, 5'd7, 5'd6, 3'b000, 5'd5));
        sendInst(encI(12'h123, 5'd9, 3'b000, 5'd8));
        waitDrain();
        endTest("reset state", errBefore);

        errBefore = errors;
        bpMode = 1;
        randomMix(300, 15, 0);
        waitDrain();
        endTest("random ALU", errBefore);

        errBefore = errors;
        nextPc = $urandom & 32'hffff_fffc;
        randomMix(60, 31, 100);
        bpMode = 0;
        waitDrain();
        endTest("LUI and AUIPC", errBefore);

        errBefore = errors;
        prevRd = 5'd1;
        for (int i = 0; i < 80; i++) begin
            rd = regAddr_t'($urandom_range(1, 3));
            if ($urandom_range(0, 1) == 0) begin
                sendInst(encR(7'b0, prevRd, prevRd, 3'($urandom_range(0, 7)), rd));
            end else begin
                sendInst(encI(12'($urandom), prevRd, 3'b000, rd));
            end
            prevRd = rd;
        end
        waitDrain();
        // distinct writes queued behind a stalled writeback and then readers of all of them
        holdLeft = 20;
        bpMode   = 3;
        for (int i = 0; i < trackDepth; i++) begin
            sendInst(encI(12'(i + 1), regAddr_t'(10 + i), 3'b000, regAddr_t'(10 + i)));
        end
        for (int i = 0; i < trackDepth; i++) begin
            sendInst(encR(7'b0, regAddr_t'(10 + i), regAddr_t'(10 + (i + 1) % trackDepth),
                          3'b000, regAddr_t'(20 + i)));
        end
        waitDrain();
        endTest("dependent chains", errBefore);

        errBefore = errors;
        bpMode = 2;
        randomMix(200, 10, 15);
        bpMode = 0;
        waitDrain();
        endTest("writeback back-pressure", errBefore);

        errBefore = errors;
        bpMode = 1;
        sendInst(encI(12'h7ff, 5'd5, 3'b000, 5'd0));
        sendInst(encR(7'b0, 5'd2, 5'd1, 3'b000, 5'd0));
        sendInst(encU(opcLui, 20'habcde, 5'd0));
        sendInst(encU(opcAuipc, 20'h12345, 5'd0));
        for (int i = 0; i < 12; i++) begin
            do begin
                opc = 7'($urandom);
            end while (opc == opcOp || opc == opcOpImm || opc == opcLui || opc == opcAuipc);
            sendInst({25'($urandom), opc});
        end
        sendInst(encR(7'b0, 5'd0, 5'd0, 3'b000, 5'd6));
        sendInst(encI(12'hffd, 5'd0, 3'b000, 5'd7));
        sendInst(encR(7'b0, 5'd0, 5'd7, 3'b110, 5'd8));
        bpMode = 0;
        waitDrain();
        endTest("x0 and unsupported opcodes", errBefore);

        reportAndFinish();
    end

endmodule

/* compile.f */
+incdir+dv
src/cpuPkg.sv
src/ctrlGen.sv
src/regFile.sv
src/writeTracker.sv
src/decodeStage.sv
src/aluStage.sv
src/coreDecodeTop.sv
dv/tbTop.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tbTop -o simv \
    && ./obj_dir/simv > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || exit 0
